//--- vlog.f
hdl/commit_pkg.sv
hdl/rob.sv
hdl/operand_fwd.sv
hdl/commit_ctrl.sv
hdl/commit_stage.sv
verif/tb_commit_stage.sv

//--- verif/tb_commit_stage.sv
// Testbench for the commit stage with clock, reset, LFSR stimulus,
// in-order reference model, output checks and watchdog
`default_nettype none

module tb_commit_stage import commit_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ROB_DEPTH    = 8;
  localparam int unsigned NUM_CYCLES   = 2000;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;

  logic            clk_i;
  logic            rst_n_i;
  logic            issue_valid_i;
  logic            issue_ready_o;
  issue_data_t     issue_data_i;
  rob_idx_t        issue_tail_idx_o;
  rob_idx_t        issue_rs1_rob_idx_i;
  rob_idx_t        issue_rs2_rob_idx_i;
  logic            issue_rs1_ready_o;
  logic [XLEN-1:0] issue_rs1_value_o;
  logic            issue_rs2_ready_o;
  logic [XLEN-1:0] issue_rs2_value_o;
  logic            cdb_valid_i;
  cdb_data_t       cdb_data_i;
  logic            fe_ready_i;
  mtvec_t          csr_mtvec_i;
  logic            fe_except_raised_o;
  logic [XLEN-1:0] fe_except_pc_o;
  logic            rd_valid_o;
  logic [REG_IDX_W-1:0] rd_idx_o;
  logic [XLEN-1:0] rd_value_o;
  logic            ex_mis_flush_o;
  logic            except_flush_o;

  // Reference model of ROB contents in order, commit register and trap wait
  comm_data_t model_q[$];
  comm_data_t model_reg;
  logic       model_reg_valid;
  logic       model_wait;
  rob_idx_t   model_tail;
  logic       issue_accepted;
  logic       flushed;

  // Inputs for the next cycle
  logic        nxt_issue_valid;
  issue_data_t nxt_issue_data;
  logic        nxt_cdb_valid;
  cdb_data_t   nxt_cdb_data;
  logic        nxt_fe_ready;
  mtvec_t      nxt_mtvec;
  rob_idx_t    nxt_rs1;
  rob_idx_t    nxt_rs2;

  int unsigned n_commit;
  int unsigned n_mis;
  int unsigned n_trap;
  int unsigned n_stall;
  int unsigned n_full;
  logic        traffic_ok;
  logic [31:0] lfsr_state = 32'h7e77bb4f;

  commit_stage #(.ROB_DEPTH(ROB_DEPTH)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic int find_entry(input rob_idx_t idx);
    foreach (model_q[i]) begin
      if (model_q[i].rob_idx == idx) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Priority order is CDB, allocated ROB entry, then commit register
  task automatic check_operand(input string name, input rob_idx_t idx,
                               input logic got_ready, input logic [31:0] got_value);
    logic        exp_ready;
    logic [31:0] exp_value;
    int          pos;
    pos = find_entry(idx);
    if (cdb_valid_i && (cdb_data_i.rob_idx == idx)) begin
      exp_ready = 1'b1;
      exp_value = cdb_data_i.res_value;
    end else if (pos >= 0) begin
      exp_ready = model_q[pos].entry.res_ready;
      exp_value = model_q[pos].entry.res_value;
    end else if (model_reg_valid && (model_reg.rob_idx == idx)) begin
      exp_ready = 1'b1;
      exp_value = model_reg.entry.res_value;
    end else begin
      exp_ready = 1'b0;
      exp_value = '0;
    end
    check_value({name, "_ready_o"}, 32'(got_ready), 32'(exp_ready));
    check_value({name, "_value_o"}, got_value, exp_value);
  endtask

  // ------------------------------
  // Checks against the model
  // ------------------------------
  task automatic check_outputs();
    logic        active;
    logic        exp_rd;
    logic        exp_mis;
    logic        exp_exc;
    logic [31:0] exp_pc;
    active  = model_reg_valid && !model_wait;
    exp_rd  = active && model_reg.entry.rd_we;
    exp_mis = active && model_reg.entry.except_raised &&
              (model_reg.entry.except_code == E_MISPREDICTION);
    exp_exc = model_wait && fe_ready_i;
    check_value("issue_ready_o", 32'(issue_ready_o), 32'(model_q.size() != ROB_DEPTH));
    check_value("issue_tail_idx_o", 32'(issue_tail_idx_o), 32'(model_tail));
    check_value("rd_valid_o", 32'(rd_valid_o), 32'(exp_rd));
    check_value("ex_mis_flush_o", 32'(ex_mis_flush_o), 32'(exp_mis));
    check_value("except_flush_o", 32'(except_flush_o), 32'(exp_exc));
    check_value("fe_except_raised_o", 32'(fe_except_raised_o), 32'(exp_exc));
    if (exp_rd) begin
      check_value("rd_idx_o", 32'(rd_idx_o), 32'(model_reg.entry.rd_idx));
      check_value("rd_value_o", rd_value_o, model_reg.entry.res_value);
      n_commit++;
    end
    if (exp_exc) begin
      exp_pc = 32'(csr_mtvec_i.base) * 32'd4;
      if (csr_mtvec_i.mode == 2'd1) begin
        exp_pc = exp_pc + 32'(model_reg.entry.except_code) * 32'd4;
      end
      check_value("fe_except_pc_o", fe_except_pc_o, exp_pc);
      n_trap++;
    end
    if (exp_mis) n_mis++;
    if (model_wait && !fe_ready_i) n_stall++;
    if (model_q.size() == ROB_DEPTH) n_full++;
    check_operand("issue_rs1", issue_rs1_rob_idx_i, issue_rs1_ready_o, issue_rs1_value_o);
    check_operand("issue_rs2", issue_rs2_rob_idx_i, issue_rs2_ready_o, issue_rs2_value_o);
  endtask

  // Model state after the coming rising edge
  task automatic advance_model();
    logic       mis;
    logic       flush;
    logic       comm_ready;
    logic       pop;
    logic       push;
    int         pos;
    comm_data_t e;
    mis = model_reg_valid && !model_wait && model_reg.entry.except_raised &&
          (model_reg.entry.except_code == E_MISPREDICTION);
    flush      = mis || (model_wait && fe_ready_i);
    comm_ready = !model_wait && !mis;
    pop  = comm_ready && (model_q.size() > 0) && model_q[0].entry.res_ready;
    push = issue_valid_i && (model_q.size() != ROB_DEPTH) && !flush;
    if (flush) begin
      // Everything younger than the flushing instruction is gone
      model_q.delete();
      model_reg_valid = 1'b0;
      model_wait      = 1'b0;
      model_tail      = '0;
    end else begin
      if (cdb_valid_i) begin
        pos = find_entry(cdb_data_i.rob_idx);
        if (pos >= 0) begin
          model_q[pos].entry.res_ready = 1'b1;
          model_q[pos].entry.res_value = cdb_data_i.res_value;
          if (cdb_data_i.except_raised) begin
            model_q[pos].entry.except_raised = 1'b1;
            model_q[pos].entry.except_code   = cdb_data_i.except_code;
          end
        end
      end
      if (comm_ready) begin
        model_reg_valid = pop;
        if (pop) begin
          model_reg  = model_q.pop_front();
          model_wait = model_reg.entry.except_raised &&
                       (model_reg.entry.except_code != E_MISPREDICTION);
        end
      end
      if (push) begin
        e.rob_idx             = model_tail;
        e.entry.instr_pc      = issue_data_i.instr_pc;
        e.entry.rd_idx        = issue_data_i.rd_idx;
        e.entry.rd_we         = issue_data_i.rd_we;
        e.entry.except_raised = issue_data_i.except_raised;
        e.entry.except_code   = issue_data_i.except_code;
        e.entry.res_ready     = issue_data_i.except_raised;
        e.entry.res_value     = '0;
        model_q.push_back(e);
        model_tail = (model_tail == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : model_tail + 1'b1;
      end
    end
    issue_accepted = push;
    flushed        = flush;
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic pick_inputs();
    rob_idx_t cand[$];
    // An offer stays until it is taken or flushed away
    if (!issue_valid_i || issue_accepted || flushed) begin
      nxt_issue_valid               = (rand_bits(2) != 0);
      nxt_issue_data.instr_pc       = 32'(rand_bits(30)) * 32'd4;
      nxt_issue_data.rd_idx         = REG_IDX_W'(rand_bits(REG_IDX_W));
      nxt_issue_data.rd_we          = (rand_bits(2) != 0);
      nxt_issue_data.except_raised  = (rand_bits(5) == 0);
      case (rand_bits(2))
        32'd0:   nxt_issue_data.except_code = E_ILLEGAL_INSN;
        32'd1:   nxt_issue_data.except_code = E_ECALL;
        32'd2:   nxt_issue_data.except_code = E_LD_FAULT;
        default: nxt_issue_data.except_code = E_INSN_ADDR_MISALIGNED;
      endcase
    end
    foreach (model_q[i]) begin
      if (!model_q[i].entry.res_ready) begin
        cand.push_back(model_q[i].rob_idx);
      end
    end
    nxt_cdb_valid = 1'b0;
    if ((cand.size() > 0) && rand_bits(1)) begin
      nxt_cdb_valid                = 1'b1;
      nxt_cdb_data.rob_idx         = cand[rand_bits(3) % cand.size()];
      nxt_cdb_data.res_value       = rand_bits(32);
      nxt_cdb_data.except_raised   = (rand_bits(5) == 0);
      nxt_cdb_data.except_code     = rand_bits(1) ? E_MISPREDICTION : E_LD_FAULT;
    end
    nxt_fe_ready = rand_bits(1);
    if (rand_bits(5) == 0) begin
      nxt_mtvec.base = (XLEN - 2)'(rand_bits(XLEN - 2));
      nxt_mtvec.mode = 2'(rand_bits(1));
    end
    nxt_rs1 = ROB_IDX_W'(rand_bits(ROB_IDX_W));
    nxt_rs2 = ROB_IDX_W'(rand_bits(ROB_IDX_W));
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    n_commit        = 0;
    n_mis           = 0;
    n_trap          = 0;
    n_stall         = 0;
    n_full          = 0;
    model_reg_valid = 1'b0;
    model_wait      = 1'b0;
    model_tail      = '0;
    issue_accepted  = 1'b0;
    flushed         = 1'b0;
    nxt_mtvec       = '{base: 30'h0010_0000, mode: 2'd0};
    rst_n_i             = 1'b0;
    issue_valid_i       = 1'b0;
    issue_data_i        = '0;
    issue_rs1_rob_idx_i = '0;
    issue_rs2_rob_idx_i = '0;
    cdb_valid_i         = 1'b0;
    cdb_data_i          = '0;
    fe_ready_i          = 1'b1;
    csr_mtvec_i         = nxt_mtvec;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int unsigned cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge clk_i);
      check_outputs();
      advance_model();
      pick_inputs();
      @(posedge clk_i);
      issue_valid_i       <= nxt_issue_valid;
      issue_data_i        <= nxt_issue_data;
      cdb_valid_i         <= nxt_cdb_valid;
      cdb_data_i          <= nxt_cdb_data;
      fe_ready_i          <= nxt_fe_ready;
      csr_mtvec_i         <= nxt_mtvec;
      issue_rs1_rob_idx_i <= nxt_rs1;
      issue_rs2_rob_idx_i <= nxt_rs2;
    end
    $display("Commits %0d, mispredicts %0d, traps %0d, stall cycles %0d, full cycles %0d",
             n_commit, n_mis, n_trap, n_stall, n_full);
    traffic_ok = (n_commit > 0) && (n_mis > 0) && (n_trap > 0) && (n_stall > 0) &&
                 (n_full > 0);
    if (traffic_ok) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("Stimulus never reached every commit scenario");
      abort_run();
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the run completed");
    abort_run();
  end

endmodule

`default_nettype wire

//--- hdl/commit_stage.sv
// Commit stage top level with the ROB, two operand forwarding units
// and the commit controller
`default_nettype none

module commit_stage import commit_pkg::*; #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  // Issue
  input  wire logic            issue_valid_i,
  output logic                 issue_ready_o,
  input  issue_data_t          issue_data_i,
  output rob_idx_t             issue_tail_idx_o,
  // Operand lookups
  input  rob_idx_t             issue_rs1_rob_idx_i,
  input  rob_idx_t             issue_rs2_rob_idx_i,
  output logic                 issue_rs1_ready_o,
  output logic [XLEN-1:0]      issue_rs1_value_o,
  output logic                 issue_rs2_ready_o,
  output logic [XLEN-1:0]      issue_rs2_value_o,
  // CDB
  input  wire logic            cdb_valid_i,
  input  cdb_data_t            cdb_data_i,
  // Front end and mtvec
  input  wire logic            fe_ready_i,
  input  mtvec_t               csr_mtvec_i,
  output logic                 fe_except_raised_o,
  output logic [XLEN-1:0]      fe_except_pc_o,
  // Register file
  output logic                 rd_valid_o,
  output logic [REG_IDX_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]      rd_value_o,
  // Flushes
  output logic                 ex_mis_flush_o,
  output logic                 except_flush_o
);

  rob_entry_t rs1_entry;
  rob_entry_t rs2_entry;
  logic       rs1_valid;
  logic       rs2_valid;
  logic       comm_valid;
  logic       comm_ready;
  comm_data_t comm_data;
  logic       comm_reg_valid;
  comm_data_t comm_reg;

  wire rob_flush = ex_mis_flush_o | except_flush_o;

  rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clk_i, .rst_n_i, .flush_i(rob_flush),
    .issue_valid_i, .issue_ready_o, .issue_data_i, .issue_tail_idx_o,
    .cdb_valid_i, .cdb_data_i,
    .rs1_idx_i(issue_rs1_rob_idx_i), .rs2_idx_i(issue_rs2_rob_idx_i),
    .rs1_entry_o(rs1_entry), .rs2_entry_o(rs2_entry),
    .rs1_valid_o(rs1_valid), .rs2_valid_o(rs2_valid),
    .comm_valid_o(comm_valid), .comm_ready_i(comm_ready), .comm_data_o(comm_data)
  );

  operand_fwd u_rs1_fwd (
    .rob_idx_i(issue_rs1_rob_idx_i), .cdb_valid_i, .cdb_data_i,
    .rob_valid_i(rs1_valid), .rob_entry_i(rs1_entry),
    .comm_valid_i(comm_reg_valid), .comm_data_i(comm_reg),
    .ready_o(issue_rs1_ready_o), .value_o(issue_rs1_value_o)
  );

  operand_fwd u_rs2_fwd (
    .rob_idx_i(issue_rs2_rob_idx_i), .cdb_valid_i, .cdb_data_i,
    .rob_valid_i(rs2_valid), .rob_entry_i(rs2_entry),
    .comm_valid_i(comm_reg_valid), .comm_data_i(comm_reg),
    .ready_o(issue_rs2_ready_o), .value_o(issue_rs2_value_o)
  );

  commit_ctrl u_commit_ctrl (
    .clk_i, .rst_n_i,
    .comm_valid_i(comm_valid), .comm_ready_o(comm_ready), .comm_data_i(comm_data),
    .fe_ready_i, .csr_mtvec_i,
    .comm_reg_valid_o(comm_reg_valid), .comm_reg_o(comm_reg),
    .rd_valid_o, .rd_idx_o, .rd_value_o,
    .fe_except_raised_o, .fe_except_pc_o,
    .mis_flush_o(ex_mis_flush_o), .except_flush_o
  );

endmodule

`default_nettype wire

//--- hdl/commit_ctrl.sv
// Committing-instruction register, commit FSM, trap vector adder
// and flush generation
`default_nettype none

module commit_ctrl import commit_pkg::*; (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  // ROB head
  input  wire logic            comm_valid_i,
  output logic                 comm_ready_o,
  input  comm_data_t           comm_data_i,
  // Front end and mtvec
  input  wire logic            fe_ready_i,
  input  mtvec_t               csr_mtvec_i,
  // Commit register as seen by operand forwarding
  output logic                 comm_reg_valid_o,
  output comm_data_t           comm_reg_o,
  // Register file
  output logic                 rd_valid_o,
  output logic [REG_IDX_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]      rd_value_o,
  // Redirect and flushes
  output logic                 fe_except_raised_o,
  output logic [XLEN-1:0]      fe_except_pc_o,
  output logic                 mis_flush_o,
  output logic                 except_flush_o
);

  // EXCEPT_WAIT means the register holds a trap for the front end
  typedef enum logic {
    COMMIT,
    EXCEPT_WAIT
  } state_t;

  state_t          state_q;
  state_t          state_d;
  comm_data_t      comm_reg_q;
  logic            comm_reg_valid_q;
  logic            load;
  logic            head_is_trap;
  logic            reg_is_mis;
  logic [XLEN-1:0] vec_offset;

  // ------------------------------
  // Commit register
  // ------------------------------
  assign comm_ready_o = (state_q == COMMIT) && !mis_flush_o;
  assign load         = comm_valid_i && comm_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : reg_valid
    if (!rst_n_i) begin
      comm_reg_valid_q <= 1'b0;
    end else if (mis_flush_o || except_flush_o) begin
      comm_reg_valid_q <= 1'b0;
    end else if (comm_ready_o) begin
      comm_reg_valid_q <= comm_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : reg_data
    if (load) begin
      comm_reg_q <= comm_data_i;
    end
  end

  assign comm_reg_valid_o = comm_reg_valid_q;
  assign comm_reg_o       = comm_reg_q;

  // ------------------------------
  // Commit FSM
  // ------------------------------
  // Traps are classified as the head enters the register
  assign head_is_trap = comm_data_i.entry.except_raised &&
                        (comm_data_i.entry.except_code != E_MISPREDICTION);

  always_comb begin : fsm_next
    state_d = state_q;
    case (state_q)
      COMMIT: begin
        if (load && head_is_trap) begin
          state_d = EXCEPT_WAIT;
        end
      end
      EXCEPT_WAIT: begin
        if (fe_ready_i) begin
          state_d = COMMIT;
        end
      end
      default: state_d = COMMIT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : fsm_reg
    if (!rst_n_i) begin
      state_q <= COMMIT;
    end else begin
      state_q <= state_d;
    end
  end

  // In COMMIT the register never holds a trap
  assign reg_is_mis = comm_reg_valid_q && comm_reg_q.entry.except_raised &&
                      (comm_reg_q.entry.except_code == E_MISPREDICTION);

  assign rd_valid_o  = (state_q == COMMIT) && comm_reg_valid_q && comm_reg_q.entry.rd_we;
  assign rd_idx_o    = comm_reg_q.entry.rd_idx;
  assign rd_value_o  = comm_reg_q.entry.res_value;
  assign mis_flush_o = (state_q == COMMIT) && reg_is_mis;

  assign except_flush_o     = (state_q == EXCEPT_WAIT) && fe_ready_i;
  assign fe_except_raised_o = except_flush_o;

  // Trap vector
  assign vec_offset = (csr_mtvec_i.mode == 2'd1) ?
                      {{(XLEN - 6){1'b0}}, comm_reg_q.entry.except_code, 2'b00} : '0;
  assign fe_except_pc_o = {csr_mtvec_i.base, 2'b00} + vec_offset;

  // A redirect always comes from a held trap and never from a misprediction
  a_trap_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fe_except_raised_o |-> comm_reg_valid_q && comm_reg_q.entry.except_raised &&
      (comm_reg_q.entry.except_code != E_MISPREDICTION));

endmodule

`default_nettype wire

//--- hdl/operand_fwd.sv
// Source operand resolution from CDB, ROB and commit register
`default_nettype none

module operand_fwd import commit_pkg::*; (
  input  rob_idx_t        rob_idx_i,
  input  wire logic       cdb_valid_i,
  input  cdb_data_t       cdb_data_i,
  input  wire logic       rob_valid_i,
  input  rob_entry_t      rob_entry_i,
  input  wire logic       comm_valid_i,
  input  comm_data_t      comm_data_i,
  output logic            ready_o,
  output logic [XLEN-1:0] value_o
);

  // Newest source first
  always_comb begin : fwd_sel
    if (cdb_valid_i && (cdb_data_i.rob_idx == rob_idx_i)) begin
      ready_o = 1'b1;
      value_o = cdb_data_i.res_value;
    end else if (rob_valid_i) begin
      // Allocated entry that may still wait for its result
      ready_o = rob_entry_i.res_ready;
      value_o = rob_entry_i.res_value;
    end else if (comm_valid_i && (comm_data_i.rob_idx == rob_idx_i)) begin
      ready_o = 1'b1;
      value_o = comm_data_i.entry.res_value;
    end else begin
      ready_o = 1'b0;
      value_o = '0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rob.sv
// Reorder buffer with issue allocation, CDB writeback, in-order head output
// and two source lookups by index
`default_nettype none

module rob import commit_pkg::*; #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  input  wire logic  flush_i,
  // Issue
  input  wire logic  issue_valid_i,
  output logic       issue_ready_o,
  input  issue_data_t issue_data_i,
  output rob_idx_t   issue_tail_idx_o,
  // CDB
  input  wire logic  cdb_valid_i,
  input  cdb_data_t  cdb_data_i,
  // Operand lookups
  input  rob_idx_t   rs1_idx_i,
  input  rob_idx_t   rs2_idx_i,
  output rob_entry_t rs1_entry_o,
  output rob_entry_t rs2_entry_o,
  output logic       rs1_valid_o,
  output logic       rs2_valid_o,
  // Commit
  output logic       comm_valid_o,
  input  wire logic  comm_ready_i,
  output comm_data_t comm_data_o
);

  rob_entry_t           data_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] valid_q;
  rob_idx_t             head_q;
  rob_idx_t             tail_q;
  logic [ROB_IDX_W:0]   count_q;

  logic       push;
  logic       pop;
  rob_idx_t   head_nxt;
  rob_idx_t   tail_nxt;
  rob_entry_t alloc_entry;

  assign issue_ready_o    = (count_q != ROB_DEPTH);
  assign issue_tail_idx_o = tail_q;

  assign push = issue_valid_i && issue_ready_o;
  assign pop  = comm_valid_o && comm_ready_i;

  // Pointers wrap at ROB_DEPTH rather than at the index width
  assign head_nxt = (head_q == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : head_q + 1'b1;
  assign tail_nxt = (tail_q == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : tail_q + 1'b1;

  // ------------------------------
  // Allocation and writeback
  // ------------------------------
  // An instruction that faulted at issue gets no result and is ready at once
  always_comb begin
    alloc_entry.instr_pc      = issue_data_i.instr_pc;
    alloc_entry.rd_idx        = issue_data_i.rd_idx;
    alloc_entry.rd_we         = issue_data_i.rd_we;
    alloc_entry.except_raised = issue_data_i.except_raised;
    alloc_entry.except_code   = issue_data_i.except_code;
    alloc_entry.res_ready     = issue_data_i.except_raised;
    alloc_entry.res_value     = '0;
  end

  always_ff @(posedge clk_i) begin : entry_write
    if (push) begin
      data_q[tail_q] <= alloc_entry;
    end
    if (cdb_valid_i) begin
      data_q[cdb_data_i.rob_idx].res_ready <= 1'b1;
      data_q[cdb_data_i.rob_idx].res_value <= cdb_data_i.res_value;
      if (cdb_data_i.except_raised) begin
        data_q[cdb_data_i.rob_idx].except_raised <= 1'b1;
        data_q[cdb_data_i.rob_idx].except_code   <= cdb_data_i.except_code;
      end
    end
  end

  // Occupancy and pointers
  always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
    if (!rst_n_i) begin
      valid_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        valid_q[tail_q] <= 1'b1;
        tail_q          <= tail_nxt;
      end
      if (pop) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_nxt;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ------------------------------
  // Head and lookups
  // ------------------------------
  assign comm_valid_o = valid_q[head_q] && data_q[head_q].res_ready;
  assign comm_data_o  = '{entry: data_q[head_q], rob_idx: head_q};

  // Indices past a short ROB never hit
  assign rs1_valid_o = (rs1_idx_i < ROB_DEPTH) && valid_q[rs1_idx_i];
  assign rs2_valid_o = (rs2_idx_i < ROB_DEPTH) && valid_q[rs2_idx_i];
  assign rs1_entry_o = data_q[rs1_idx_i];
  assign rs2_entry_o = data_q[rs2_idx_i];

  a_cdb_allocated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cdb_valid_i |-> valid_q[cdb_data_i.rob_idx]);

  // Occupancy count tracks the allocated entries and so stays within ROB_DEPTH
  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q == $countones(valid_q));

endmodule

`default_nettype wire

//--- hdl/commit_pkg.sv
// Shared widths, exception codes and packed structs of the commit stage
`default_nettype none

package commit_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned XLEN      = 32;
  localparam int unsigned REG_IDX_W = 5;
  localparam int unsigned ROB_IDX_W = 3;

  // Exception causes in mcause encoding where one exists
  typedef enum logic [3:0] {
    E_INSN_ADDR_MISALIGNED = 4'h0,
    E_ILLEGAL_INSN         = 4'h2,
    E_LD_FAULT             = 4'h5,
    E_ECALL                = 4'hB,
    // Marks a wrong jump/branch prediction rather than a trap
    E_MISPREDICTION        = 4'hE
  } except_code_t;

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // ------------------------------
  // Bundles
  // ------------------------------
  typedef struct packed {
    logic [XLEN-1:0]      instr_pc;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_we;
    logic                 except_raised;
    except_code_t         except_code;
  } issue_data_t;

  typedef struct packed {
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] res_value;
    logic            except_raised;
    except_code_t    except_code;
  } cdb_data_t;

  typedef struct packed {
    logic [XLEN-1:0]      instr_pc;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_we;
    logic                 except_raised;
    except_code_t         except_code;
    logic                 res_ready;
    logic [XLEN-1:0]      res_value;
  } rob_entry_t;

  typedef struct packed {
    rob_entry_t entry;
    rob_idx_t   rob_idx;
  } comm_data_t;

  // Mode 0 is direct and mode 1 is vectored
  typedef struct packed {
    logic [XLEN-3:0] base;
    logic [1:0]      mode;
  } mtvec_t;

endpackage

`default_nettype wire
